// ==== rv_decode_consts.svh ====
`ifndef RV_DECODE_CONSTS_SVH
`define RV_DECODE_CONSTS_SVH

// field widths of an rv32 instruction word
`define RV_INSTR_W   32      // full instruction word
`define RV_OPCODE_W  7       // bits 6..0
`define RV_FUNCT3_W  3       // bits 14..12
`define RV_FUNCT7_W  7       // bits 31..25

// major opcodes, low two bits always 11
`define RV_OP_LOAD   7'b0000011  // lb lh lw lbu lhu
`define RV_OP_STORE  7'b0100011  // sb sh sw, only sw decoded
`define RV_OP_IMM    7'b0010011  // i-type arithmetic
`define RV_OP_REG    7'b0110011  // r-type arithmetic
`define RV_OP_BRANCH 7'b1100011  // conditional branches
`define RV_OP_JALR   7'b1100111  // jalr, i-type
`define RV_OP_SYSTEM 7'b1110011  // csr access and mret
`define RV_OP_LUI    7'b0110111  // u-type
`define RV_OP_AUIPC  7'b0010111  // u-type, pc relative

// funct7 patterns
`define RV_F7_BASE   7'b0000000  // plain add srl and friends
`define RV_F7_ALT    7'b0100000  // sub and sra
`define RV_F7_MRET   7'b0011000  // mret, with funct3 000

`endif

// ==== rv_decode_pkg.sv ====
`default_nettype none

`include "rv_decode_consts.svh"

package rv_decode_pkg;

   typedef logic [`RV_INSTR_W-1:0]  instr_t;   // raw instruction word
   typedef logic [`RV_OPCODE_W-1:0] opcode_t;  // major opcode
   typedef logic [`RV_FUNCT3_W-1:0] funct3_t;  // minor opcode
   typedef logic [`RV_FUNCT7_W-1:0] funct7_t;  // upper function bits

   // load/store access size, word is the idle value
   typedef enum logic [1:0] {lsw_word = 2'd0, lsw_half = 2'd1, lsw_byte = 2'd2} lswidth_e;

   // zero means no branch, so a cleared word never branches
   typedef enum logic [2:0] {br_none = 3'd0, br_eq = 3'd1, br_ne = 3'd2} branch_type_e;

   // coarse alu group, refined later by the alu decoder
   typedef enum logic [1:0] {alu_addr = 2'd0, alu_branch = 2'd1, alu_arith = 2'd2} alu_op_e;

   typedef enum logic [2:0] {
      imm_r = 3'd0,     // no immediate
      imm_i = 3'd1,
      imm_s = 3'd2,
      imm_b = 3'd3,
      imm_u = 3'd4
   } imm_type_e;

   typedef enum logic [1:0] {csr_write = 2'd0, csr_set = 2'd1, csr_clear = 2'd2} csr_wsc_e;

   typedef enum logic [5:0] {
      insn_illegal,
      insn_lw, insn_lh, insn_lhu, insn_lb, insn_lbu,           // loads
      insn_sw,                                                 // store
      insn_addi, insn_andi, insn_ori, insn_xori, insn_sltiu,   // i-type alu
      insn_add, insn_sub, insn_and, insn_or, insn_xor,         // r-type alu
      insn_sltu, insn_sll, insn_srl, insn_sra,
      insn_beq, insn_bne, insn_jalr,                           // control flow
      insn_lui, insn_auipc,
      insn_csrrw, insn_csrrs, insn_csrrc,                      // csr via rs1
      insn_csrrwi, insn_csrrsi, insn_csrrci,                   // csr via uimm
      insn_mret
   } insn_kind_e;

   // main decoder control word, msb first
   typedef struct packed {
      lswidth_e     lswidth;        // 23:22
      logic         load_sign_ext;  // 21
      logic         lui;            // 20
      logic         auipc;          // 19
      logic         mret;           // 18
      logic         csr;            // 17 csr enable
      logic         csr_uimm;       // 16 rs1 field used as uimm
      csr_wsc_e     csr_wsc;        // 15:14
      logic         mem_to_reg;     // 13
      logic         mem_write;      // 12
      branch_type_e branch_type;    // 11:9
      logic         alu_src;        // 8 0 rs2, 1 imm
      logic         reg_write;      // 7
      logic         jump;           // 6
      alu_op_e      alu_op;         // 5:4
      imm_type_e    imm_type;       // 3:1
      logic         ill_instr;      // 0
   } ctrl_word_s;

endpackage

`default_nettype wire

// ==== rv_insn_match.sv ====
`default_nettype none

`include "rv_decode_consts.svh"

module rv_insn_match (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      in_valid,
   input  rv_decode_pkg::instr_t     in_instr,
   output logic                      in_ready,
   output logic                      kind_valid,
   output rv_decode_pkg::insn_kind_e kind,
   input  logic                      kind_ready
);

   rv_decode_pkg::opcode_t    opcode;
   rv_decode_pkg::funct3_t    funct3;
   rv_decode_pkg::funct7_t    funct7;
   rv_decode_pkg::insn_kind_e kind_next;

   assign opcode = in_instr[6:0];
   assign funct3 = in_instr[14:12];
   assign funct7 = in_instr[31:25];

   always_comb begin
      kind_next = rv_decode_pkg::insn_illegal; // anything unmatched
      case (opcode)
         `RV_OP_LOAD: begin
            case (funct3)
               3'b000:  kind_next = rv_decode_pkg::insn_lb;
               3'b001:  kind_next = rv_decode_pkg::insn_lh;
               3'b010:  kind_next = rv_decode_pkg::insn_lw;
               3'b100:  kind_next = rv_decode_pkg::insn_lbu;
               3'b101:  kind_next = rv_decode_pkg::insn_lhu;
               default: kind_next = rv_decode_pkg::insn_illegal;
            endcase
         end
         `RV_OP_STORE: begin
            if (funct3 == 3'b010) kind_next = rv_decode_pkg::insn_sw; // sb sh not supported
         end
         `RV_OP_IMM: begin
            case (funct3)
               3'b000:  kind_next = rv_decode_pkg::insn_addi;
               3'b011:  kind_next = rv_decode_pkg::insn_sltiu;
               3'b100:  kind_next = rv_decode_pkg::insn_xori;
               3'b110:  kind_next = rv_decode_pkg::insn_ori;
               3'b111:  kind_next = rv_decode_pkg::insn_andi;
               default: kind_next = rv_decode_pkg::insn_illegal; // slli slti srli srai
            endcase
         end
         `RV_OP_REG: begin
            if (funct7 == `RV_F7_BASE) begin
               case (funct3)
                  3'b000:  kind_next = rv_decode_pkg::insn_add;
                  3'b001:  kind_next = rv_decode_pkg::insn_sll;
                  3'b011:  kind_next = rv_decode_pkg::insn_sltu;
                  3'b100:  kind_next = rv_decode_pkg::insn_xor;
                  3'b101:  kind_next = rv_decode_pkg::insn_srl;
                  3'b110:  kind_next = rv_decode_pkg::insn_or;
                  3'b111:  kind_next = rv_decode_pkg::insn_and;
                  default: kind_next = rv_decode_pkg::insn_illegal; // slt
               endcase
            end else if (funct7 == `RV_F7_ALT && funct3 == 3'b000) begin
               kind_next = rv_decode_pkg::insn_sub;
            end else if (funct7 == `RV_F7_ALT && funct3 == 3'b101) begin
               kind_next = rv_decode_pkg::insn_sra;
            end
         end
         `RV_OP_BRANCH: begin
            if (funct3 == 3'b000) kind_next = rv_decode_pkg::insn_beq;
            if (funct3 == 3'b001) kind_next = rv_decode_pkg::insn_bne; // blt etc stay illegal
         end
         `RV_OP_JALR: begin
            if (funct3 == 3'b000) kind_next = rv_decode_pkg::insn_jalr;
         end
         `RV_OP_SYSTEM: begin
            case (funct3)
               3'b000: begin
                  if (funct7 == `RV_F7_MRET) kind_next = rv_decode_pkg::insn_mret; // ecall ebreak not
               end
               3'b001:  kind_next = rv_decode_pkg::insn_csrrw;
               3'b010:  kind_next = rv_decode_pkg::insn_csrrs;
               3'b011:  kind_next = rv_decode_pkg::insn_csrrc;
               3'b101:  kind_next = rv_decode_pkg::insn_csrrwi;
               3'b110:  kind_next = rv_decode_pkg::insn_csrrsi;
               3'b111:  kind_next = rv_decode_pkg::insn_csrrci;
               default: kind_next = rv_decode_pkg::insn_illegal;
            endcase
         end
         `RV_OP_LUI:   kind_next = rv_decode_pkg::insn_lui;
         `RV_OP_AUIPC: kind_next = rv_decode_pkg::insn_auipc;
         default:      kind_next = rv_decode_pkg::insn_illegal; // fence, jal, zero word
      endcase
   end

   // one-entry slot, accepts when empty or draining this cycle
   assign in_ready = ~kind_valid | kind_ready;

   always_ff @(posedge clk) begin
      if (reset) begin
         kind_valid <= 1'b0;
      end else if (in_ready) begin
         kind_valid <= in_valid; // refill or go empty
      end
   end

   always_ff @(posedge clk) begin
      if (in_valid && in_ready) begin
         kind <= kind_next; // payload only, no reset
      end
   end

endmodule

`default_nettype wire

// ==== rv_ctrl_gen.sv ====
`default_nettype none

module rv_ctrl_gen (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      kind_valid,
   input  rv_decode_pkg::insn_kind_e kind,
   output logic                      kind_ready,
   output logic                      out_valid,
   output rv_decode_pkg::ctrl_word_s out_ctrl,
   input  logic                      out_ready
);

   rv_decode_pkg::ctrl_word_s ctrl_next;

   always_comb begin
      ctrl_next = '0;
      ctrl_next.alu_src = 1'b1; // immediate by default
      case (kind)
         rv_decode_pkg::insn_lw, rv_decode_pkg::insn_lh, rv_decode_pkg::insn_lhu,
         rv_decode_pkg::insn_lb, rv_decode_pkg::insn_lbu: begin
            ctrl_next.mem_to_reg = 1'b1;
            ctrl_next.reg_write  = 1'b1;
            ctrl_next.alu_op     = rv_decode_pkg::alu_addr;  // base plus offset
            ctrl_next.imm_type   = rv_decode_pkg::imm_i;
         end
         rv_decode_pkg::insn_sw: begin
            ctrl_next.mem_write = 1'b1;
            ctrl_next.alu_op    = rv_decode_pkg::alu_addr;
            ctrl_next.imm_type  = rv_decode_pkg::imm_s;     // split offset
         end
         rv_decode_pkg::insn_addi, rv_decode_pkg::insn_andi, rv_decode_pkg::insn_ori,
         rv_decode_pkg::insn_xori, rv_decode_pkg::insn_sltiu: begin
            ctrl_next.reg_write = 1'b1;
            ctrl_next.alu_op    = rv_decode_pkg::alu_arith;
            ctrl_next.imm_type  = rv_decode_pkg::imm_i;
         end
         rv_decode_pkg::insn_add, rv_decode_pkg::insn_sub, rv_decode_pkg::insn_and,
         rv_decode_pkg::insn_or, rv_decode_pkg::insn_xor, rv_decode_pkg::insn_sltu,
         rv_decode_pkg::insn_sll, rv_decode_pkg::insn_srl, rv_decode_pkg::insn_sra: begin
            ctrl_next.alu_src   = 1'b0;                     // second operand from rs2
            ctrl_next.reg_write = 1'b1;
            ctrl_next.alu_op    = rv_decode_pkg::alu_arith; // funct bits resolve the op
            ctrl_next.imm_type  = rv_decode_pkg::imm_r;
         end
         rv_decode_pkg::insn_beq, rv_decode_pkg::insn_bne: begin
            ctrl_next.branch_type = (kind == rv_decode_pkg::insn_beq) ?
                                    rv_decode_pkg::br_eq : rv_decode_pkg::br_ne;
            ctrl_next.alu_src     = 1'b0;                   // compare rs1 with rs2
            ctrl_next.alu_op      = rv_decode_pkg::alu_branch;
            ctrl_next.imm_type    = rv_decode_pkg::imm_b;
         end
         rv_decode_pkg::insn_jalr: begin
            ctrl_next.reg_write = 1'b1; // link address
            ctrl_next.jump      = 1'b1;
            ctrl_next.alu_op    = rv_decode_pkg::alu_addr;
            ctrl_next.imm_type  = rv_decode_pkg::imm_i;
         end
         rv_decode_pkg::insn_lui, rv_decode_pkg::insn_auipc: begin
            ctrl_next.lui       = (kind == rv_decode_pkg::insn_lui);
            ctrl_next.auipc     = (kind == rv_decode_pkg::insn_auipc);
            ctrl_next.reg_write = 1'b1;
            ctrl_next.alu_op    = rv_decode_pkg::alu_addr;
            ctrl_next.imm_type  = rv_decode_pkg::imm_u;     // upper 20 bits
         end
         rv_decode_pkg::insn_csrrw, rv_decode_pkg::insn_csrrs, rv_decode_pkg::insn_csrrc,
         rv_decode_pkg::insn_csrrwi, rv_decode_pkg::insn_csrrsi,
         rv_decode_pkg::insn_csrrci: begin
            ctrl_next.csr       = 1'b1;
            ctrl_next.reg_write = 1'b1; // old csr value to rd
            ctrl_next.imm_type  = rv_decode_pkg::imm_i;     // csr address field
         end
         rv_decode_pkg::insn_mret: begin
            ctrl_next.mret     = 1'b1;
            ctrl_next.imm_type = rv_decode_pkg::imm_i;
         end
         default: begin
            // unknown word, nothing may change architectural state
            ctrl_next           = '0;
            ctrl_next.ill_instr = 1'b1;
         end
      endcase

      case (kind)
         rv_decode_pkg::insn_lh: begin
            ctrl_next.lswidth       = rv_decode_pkg::lsw_half;
            ctrl_next.load_sign_ext = 1'b1;
         end
         rv_decode_pkg::insn_lb: begin
            ctrl_next.lswidth       = rv_decode_pkg::lsw_byte;
            ctrl_next.load_sign_ext = 1'b1;
         end
         rv_decode_pkg::insn_lhu: ctrl_next.lswidth = rv_decode_pkg::lsw_half; // zero extend
         rv_decode_pkg::insn_lbu: ctrl_next.lswidth = rv_decode_pkg::lsw_byte; // zero extend
         rv_decode_pkg::insn_csrrs, rv_decode_pkg::insn_csrrsi:
            ctrl_next.csr_wsc = rv_decode_pkg::csr_set;
         rv_decode_pkg::insn_csrrc, rv_decode_pkg::insn_csrrci:
            ctrl_next.csr_wsc = rv_decode_pkg::csr_clear;
         default: ctrl_next.lswidth = rv_decode_pkg::lsw_word; // word and csr_write stay
      endcase

      // immediate forms take the rs1 field as a 5-bit uimm
      ctrl_next.csr_uimm = (kind == rv_decode_pkg::insn_csrrwi) ||
                           (kind == rv_decode_pkg::insn_csrrsi) ||
                           (kind == rv_decode_pkg::insn_csrrci);
   end

   assign kind_ready = ~out_valid | out_ready; // slot empty or draining

   always_ff @(posedge clk) begin
      if (reset) begin
         out_valid <= 1'b0;
      end else if (kind_ready) begin
         out_valid <= kind_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (kind_valid && kind_ready) begin
         out_ctrl <= ctrl_next; // control word held until taken
      end
   end

endmodule

`default_nettype wire

// ==== rv_decode_top.sv ====
`default_nettype none

module rv_decode_top (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      in_valid,
   input  rv_decode_pkg::instr_t     in_instr,
   output logic                      in_ready,
   output logic                      out_valid,
   output rv_decode_pkg::ctrl_word_s out_ctrl,
   input  logic                      out_ready
);

   logic                      kind_valid; // stage 1 slot full
   rv_decode_pkg::insn_kind_e kind;       // matched instruction
   logic                      kind_ready; // stage 2 can take it

   rv_insn_match u_match (
      .clk        (clk),
      .reset      (reset),
      .in_valid   (in_valid),
      .in_instr   (in_instr),
      .in_ready   (in_ready),
      .kind_valid (kind_valid),
      .kind       (kind),
      .kind_ready (kind_ready)
   );

   rv_ctrl_gen u_ctrl (
      .clk        (clk),
      .reset      (reset),
      .kind_valid (kind_valid),
      .kind       (kind),
      .kind_ready (kind_ready),
      .out_valid  (out_valid),
      .out_ctrl   (out_ctrl),
      .out_ready  (out_ready)
   );

endmodule

`default_nettype wire

// ==== rv_decode_tb.sv ====
`default_nettype none

module rv_decode_tb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int NUM_VECTORS = 42;                    // pairs in the data file
   localparam int RAND_WORDS  = 2 * NUM_VECTORS;       // words in the stalled run
   localparam int WATCHDOG_NS = NUM_VECTORS * 20 * 40; // 20 cycles of 40 ns per entry

   logic                      clk;
   logic                      reset;
   logic                      in_valid;
   rv_decode_pkg::instr_t     in_instr;
   logic                      in_ready;
   logic                      out_valid;
   rv_decode_pkg::ctrl_word_s out_ctrl;
   logic                      out_ready;

   logic [31:0] testdata [0:127];   // instr in even words and expected in odd words
   logic        ready_pat [0:255];  // random out_ready levels
   logic        stall_mode  = 1'b0;
   logic        timing_mode = 1'b0; // latency and spacing checked
   logic [23:0] exp_q [$];          // scoreboard with the oldest first
   int          acc_q [$];          // acceptance cycle per item
   string       name_q [$];
   string       phase;
   int          cycle_count    = 0;
   int          last_out_cycle = -1;
   int          in_count       = 0;
   int          out_count      = 0;
   int          value_errors   = 0;
   int          other_errors   = 0;

   rv_decode_top u_rv_decode_top (
      .clk       (clk),
      .reset     (reset),
      .in_valid  (in_valid),
      .in_instr  (in_instr),
      .in_ready  (in_ready),
      .out_valid (out_valid),
      .out_ctrl  (out_ctrl),
      .out_ready (out_ready)
   );

   always #20 clk = ~clk; // 40 ns period

   always @(posedge clk) cycle_count <= cycle_count + 1;

   // sink side with random low periods only in the stalled run
   always @(posedge clk) begin
      #2;
      if (stall_mode) out_ready = ready_pat[cycle_count[7:0]];
      else out_ready = 1'b1;
   end

   // present one word and hold it until taken
   task automatic drive_word(input logic [5:0] idx);
      logic [6:0]  addr;
      logic [31:0] exp_word;
      addr     = {idx, 1'b0};
      exp_word = testdata[addr + 7'd1];
      in_valid = 1'b1;
      in_instr = testdata[addr];
      @(negedge clk);
      while (!in_ready) @(negedge clk); // handshake decided mid cycle
      exp_q.push_back(exp_word[23:0]);
      acc_q.push_back(cycle_count);
      name_q.push_back($sformatf("%s vector %0d", phase, idx));
      in_count++;
      @(posedge clk); // transfer edge
      #2;
      in_valid = 1'b0;
   endtask

   task automatic wait_drain();
      while (exp_q.size() != 0) @(negedge clk);
      repeat (4) @(negedge clk); // room for stray results
   endtask

   // output monitor sampled mid cycle where everything is settled
   always @(negedge clk) begin
      logic [23:0]               got;
      logic [23:0]               want;
      rv_decode_pkg::ctrl_word_s got_s;
      string                     tname;
      int                        lat;
      if (!reset && out_valid && out_ready) begin
         got   = out_ctrl;
         got_s = out_ctrl;
         out_count++;
         assert (exp_q.size() != 0) else begin
            $display("result delivered with no instruction outstanding, cycle %0d",
                     cycle_count);
            other_errors++;
         end
         if (exp_q.size() != 0) begin
            want  = exp_q.pop_front();
            lat   = cycle_count - acc_q.pop_front();
            tname = name_q.pop_front();
            assert (got == want) else begin
               $display("[ERROR] %s: expected %06h, actual %06h", tname, want, got);
               value_errors++;
            end
            // illegal word must come out as the bare safe word
            assert (!got_s.ill_instr || got == 24'h000001) else begin
               $display("[ERROR] %s safe word: expected 000001, actual %06h", tname, got);
               value_errors++;
            end
            if (timing_mode) begin
               assert (lat == 2) else begin
                  $display("[ERROR] %s latency: expected 2, actual %0d", tname, lat);
                  value_errors++;
               end
               if (last_out_cycle >= 0) begin
                  assert (cycle_count == last_out_cycle + 1) else begin
                     $display("[ERROR] %s spacing: expected 1, actual %0d", tname,
                              cycle_count - last_out_cycle);
                     value_errors++;
                  end
               end
               last_out_cycle = cycle_count;
            end
         end
      end
   end

   initial begin
      logic [8:0] k;
      logic [5:0] v;
      logic [5:0] idx;
      int         gap;
      int         n;
      clk       = 1'b0;
      reset     = 1'b1;
      in_valid  = 1'b0;
      in_instr  = '0;
      out_ready = 1'b1;
      void'($urandom(61));
      for (k = 9'd0; k < 9'd256; k++) ready_pat[k[7:0]] = ($urandom % 4) != 0; // 1 in 4 low
      $readmemh("rv_decode_testdata.hex", testdata);
      for (v = 6'd0; v < 6'(NUM_VECTORS); v++) begin
         // no legal or safe control word is zero
         assert (!$isunknown(testdata[{v, 1'b1}]) && testdata[{v, 1'b1}] != 32'd0 &&
                 testdata[{v, 1'b1}][31:24] == 8'h00) else begin
            $display("data file entry %0d is missing or malformed", v);
            other_errors++;
         end
      end

      repeat (5) @(posedge clk);
      #2;
      reset = 1'b0;
      @(negedge clk); // level seen by the first edge after release
      assert (!out_valid && in_ready) else begin
         $display("after reset release out_valid is high or in_ready is low");
         other_errors++;
      end

      // back to back with the sink always ready
      @(posedge clk);
      #2;
      phase       = "in order";
      timing_mode = 1'b1;
      for (v = 6'd0; v < 6'(NUM_VECTORS); v++) drive_word(v);
      wait_drain();
      stall_mode = 1'b1; // set mid cycle away from the drive time
      @(posedge clk);
      #2;
      timing_mode = 1'b0;

      // random gaps and stalls
      phase = "random";
      for (n = 0; n < RAND_WORDS; n++) begin
         idx = 6'($urandom % NUM_VECTORS);
         drive_word(idx);
         gap = int'($urandom % 3);
         repeat (gap) begin
            @(posedge clk);
            #2;
         end
      end
      @(negedge clk);
      stall_mode = 1'b0;
      wait_drain();

      assert (in_count == out_count) else begin
         $display("%0d instructions accepted but %0d results delivered", in_count, out_count);
         other_errors++;
      end
      $display("checks done: %0d value errors, %0d other errors", value_errors, other_errors);
      if (value_errors + other_errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("watchdog expired after %0d ns with %0d results outstanding",
               WATCHDOG_NS, exp_q.size());
      $display("TESTBENCH FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== rv_decode_testdata.hex ====
// columns: instruction word, expected 24-bit control word in ctrl_word_s bit order
// legal instructions first, then words that must decode as illegal
00012083 002182 // lw    x1, 0(x2)
00011083 602182 // lh
00015083 402182 // lhu
00010083 A02182 // lb
00014083 802182 // lbu
00112023 001104 // sw    x1, 0(x2)
00110093 0001A2 // addi  x1, x2, 1
00117093 0001A2 // andi
00116093 0001A2 // ori
00114093 0001A2 // xori
00113093 0001A2 // sltiu
003100B3 0000A0 // add   x1, x2, x3
403100B3 0000A0 // sub
003170B3 0000A0 // and
003160B3 0000A0 // or
003140B3 0000A0 // xor
003130B3 0000A0 // sltu
003110B3 0000A0 // sll
003150B3 0000A0 // srl
403150B3 0000A0 // sra
00208063 000216 // beq   x1, x2, 0
00209063 000416 // bne
000100E7 0001C2 // jalr  x1, 0(x2)
123450B7 100188 // lui   x1, 0x12345
00001097 080188 // auipc x1, 1
300110F3 020182 // csrrw  x1, mstatus, x2
300120F3 024182 // csrrs
300130F3 028182 // csrrc
3002D0F3 030182 // csrrwi x1, mstatus, 5
3002E0F3 034182 // csrrsi
3002F0F3 038182 // csrrci
30200073 040102 // mret
0000007F 000001 // unknown opcode
403170B3 000001 // alt funct7 on funct3 111
00112093 000001 // slti
0FF0000F 000001 // fence
00000000 000001 // all zero word
0020C063 000001 // blt
00111093 000001 // slli
008000EF 000001 // jal
00000073 000001 // ecall
00110023 000001 // sb

// ==== rv_decode.f ====
+incdir+.
rv_decode_pkg.sv
rv_insn_match.sv
rv_ctrl_gen.sv
rv_decode_top.sv
rv_decode_tb.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = rv_decode_tb
FILELIST = rv_decode.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TESTBENCH PASSED" $(LOG) || (echo "no pass message in log"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
